//--- cpu_macros.svh
// address and data widths, boot block geometry, data memory depth
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

//////////////////////////////////////////////////
// bus widths
//////////////////////////////////////////////////
`define CPU_ADDR_W      16      // byte address, host and accel side
`define CPU_DATA_W      32      // one word

//////////////////////////////////////////////////
// line and block geometry
//////////////////////////////////////////////////
`define CPU_LINE_WORDS  16      // words per boot block and per accel line
`define CPU_LINE_W      512     // CPU_LINE_WORDS * CPU_DATA_W

`define CPU_DM_BLOCKS   17      // blocks fetched from the host at boot
`define CPU_DM_WORDS    16384   // 64 KB of data memory

`endif

//--- host_pkg.sv
// host link types: operation enum, request and response structs
package host_pkg;

`include "cpu_macros.svh"

    // same codes as the host side expects
    typedef enum logic [1:0] {
        host_idle  = 2'b00,
        host_read  = 2'b01,
        host_write = 2'b11      // never issued here
    } host_op_t;

    // loader -> host
    typedef struct packed {
        host_op_t                op;
        logic [`CPU_ADDR_W-1:0]  addr;
    } host_req_t;

    // host -> loader, rd_valid marks the first word of a block
    typedef struct packed {
        logic                    rd_valid;
        logic                    tx_done;   // high with the last word
        logic [`CPU_DATA_W-1:0]  data;
    } host_rsp_t;

endpackage

//--- mem_pkg.sv
// memory side types: boot FSM states, loader write port, accel request and response
package mem_pkg;

`include "cpu_macros.svh"

    typedef enum logic [1:0] {
        st_idle,        // waiting for host ready
        st_wait_block,  // read issued, waiting on rd_valid
        st_burst,       // streaming the rest of the block
        st_run          // fill complete
    } boot_state_t;

    // loader write into data memory
    typedef struct packed {
        logic                    en;
        logic [`CPU_ADDR_W-1:0]  addr;   // byte address
        logic [`CPU_DATA_W-1:0]  data;
    } dm_wr_t;

    typedef struct packed {
        logic                    wrt_en;
        logic                    rd_en;
        logic [`CPU_ADDR_W-1:0]  addr;
        logic [`CPU_DATA_W-1:0]  wrt_data;
    } accel_req_t;

    typedef struct packed {
        logic                    wrt_done;  // one cycle after the write
        logic                    rd_valid;  // one cycle after rd_en
        logic [`CPU_LINE_W-1:0]  rd_data;   // word i at bits 32i +: 32
    } accel_rsp_t;

endpackage

//--- boot_addr_gen.sv
// boot block base table, block counter and running word address
`timescale 1ns/1ps
`include "cpu_macros.svh"

module boot_addr_gen (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   set,         // load base + 4
    input  logic                   inc,         // step one word
    input  logic                   next_block,  // move to the next table entry
    output logic [`CPU_ADDR_W-1:0] block_addr,
    output logic [`CPU_ADDR_W-1:0] word_addr,
    output logic                   last_block
);

    localparam int cnt_w = $clog2(`CPU_DM_BLOCKS);

    //////////////////////////////////////////////////
    // block bases in fetch order
    //////////////////////////////////////////////////
    localparam logic [`CPU_ADDR_W-1:0] blk_base [0:`CPU_DM_BLOCKS-1] = '{
        16'h1000, 16'h1040, 16'h1100, 16'h1140,
        16'h2000, 16'h2040, 16'h2100, 16'h2140,
        16'h3000, 16'h3040, 16'h3100, 16'h3140,
        16'h4000, 16'h4040, 16'h4100, 16'h4140,
        16'h0100                                    // odd one out, fetched last
    };

    logic [cnt_w-1:0]       blk_cnt;
    logic [`CPU_ADDR_W-1:0] cur_addr;

    // block counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk_cnt <= '0;
        end else if (next_block) begin
            blk_cnt <= blk_cnt + 1'b1;
        end
    end

    // first word goes to the base itself, so the stream starts one word in
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_addr <= '0;
        end else if (set) begin
            cur_addr <= blk_base[blk_cnt] + `CPU_ADDR_W'(4);
        end else if (inc) begin
            cur_addr <= cur_addr + `CPU_ADDR_W'(4);
        end
    end

    assign block_addr = blk_base[blk_cnt];
    assign word_addr  = cur_addr;
    assign last_block = (blk_cnt == cnt_w'(`CPU_DM_BLOCKS - 1));

endmodule

//--- boot_loader.sv
// host transfer FSM that fills data memory block by block and flags boot done
`timescale 1ns/1ps
`include "cpu_macros.svh"

module boot_loader (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   ready,
    input  host_pkg::host_rsp_t    host_rsp,
    output host_pkg::host_req_t    host_req,
    input  logic [`CPU_ADDR_W-1:0] block_addr,
    input  logic [`CPU_ADDR_W-1:0] word_addr,
    input  logic                   last_block,
    output logic                   set,
    output logic                   inc,
    output logic                   next_block,
    output mem_pkg::dm_wr_t        dm_wr,
    output logic                   booted
);

    mem_pkg::boot_state_t state, state_nxt;

    //////////////////////////////////////////////////
    // state register
    //////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mem_pkg::st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    //////////////////////////////////////////////////
    // next state and outputs
    //////////////////////////////////////////////////
    always_comb begin
        state_nxt     = state;
        host_req.op   = host_pkg::host_idle;
        host_req.addr = '0;
        dm_wr.en      = 1'b0;
        dm_wr.addr    = '0;
        dm_wr.data    = host_rsp.data;     // host word always on the data lines
        set           = 1'b0;
        inc           = 1'b0;
        next_block    = 1'b0;

        case (state)
            mem_pkg::st_idle: begin
                if (ready) begin
                    state_nxt = mem_pkg::st_wait_block;
                end
            end

            mem_pkg::st_wait_block: begin
                host_req.op   = host_pkg::host_read;
                host_req.addr = block_addr;
                set           = 1'b1;       // keeps word_addr at base + 4
                if (host_rsp.rd_valid) begin
                    // first word lands on the block base
                    dm_wr.en   = 1'b1;
                    dm_wr.addr = block_addr;
                    state_nxt  = mem_pkg::st_burst;
                end
            end

            mem_pkg::st_burst: begin
                host_req.op   = host_pkg::host_read;
                host_req.addr = block_addr;
                dm_wr.en      = 1'b1;       // one word every cycle
                dm_wr.addr    = word_addr;
                inc           = 1'b1;
                if (host_rsp.tx_done) begin
                    if (last_block) begin
                        state_nxt = mem_pkg::st_run;
                    end else begin
                        next_block = 1'b1;
                        state_nxt  = mem_pkg::st_wait_block;
                    end
                end
            end

            mem_pkg::st_run: begin
                // boot finished, link stays idle
            end

            default: begin
                state_nxt = mem_pkg::st_idle;
            end
        endcase
    end

    assign booted = (state == mem_pkg::st_run);

endmodule

//--- data_mem.sv
// word-addressed data memory with loader write port and accel word-write / line-read port
`timescale 1ns/1ps
`include "cpu_macros.svh"

module data_mem (
    input  logic                clk,
    input  logic                rst_n,
    input  mem_pkg::dm_wr_t     dm_wr,
    input  logic                booted,
    input  mem_pkg::accel_req_t accel_req,
    output mem_pkg::accel_rsp_t accel_rsp
);

    localparam int idx_w = $clog2(`CPU_DM_WORDS);     // word index bits
    localparam int off_w = $clog2(`CPU_LINE_WORDS);   // word within a line

    logic [`CPU_DATA_W-1:0] mem [0:`CPU_DM_WORDS-1];

    logic                   accel_wr;
    logic                   accel_rd;
    logic                   wr_en;
    logic [idx_w-1:0]       wr_idx;
    logic [`CPU_DATA_W-1:0] wr_data;
    logic [idx_w-1:0]       line_base;
    logic [`CPU_LINE_W-1:0] rd_line;
    logic                   wrt_done_q;
    logic                   rd_valid_q;

    // accel port is dead until boot completes
    assign accel_wr = booted & accel_req.wrt_en;
    assign accel_rd = booted & accel_req.rd_en;

    //////////////////////////////////////////////////
    // shared write port
    //////////////////////////////////////////////////
    assign wr_en   = dm_wr.en | accel_wr;
    assign wr_idx  = accel_wr ? accel_req.addr[idx_w+1:2] : dm_wr.addr[idx_w+1:2];
    assign wr_data = accel_wr ? accel_req.wrt_data : dm_wr.data;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_idx] <= wr_data;
        end
    end

    //////////////////////////////////////////////////
    // line read, 64-byte aligned
    //////////////////////////////////////////////////
    assign line_base = {accel_req.addr[idx_w+1:off_w+2], {off_w{1'b0}}};

    // same-edge write is not visible here, read sees the old word
    always_ff @(posedge clk) begin
        if (accel_rd) begin
            for (int i = 0; i < `CPU_LINE_WORDS; i++) begin
                rd_line[i*`CPU_DATA_W +: `CPU_DATA_W] <= mem[line_base | idx_w'(i)];
            end
        end
    end

    // single-cycle strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrt_done_q <= 1'b0;
            rd_valid_q <= 1'b0;
        end else begin
            wrt_done_q <= accel_wr;
            rd_valid_q <= accel_rd;
        end
    end

    assign accel_rsp.wrt_done = wrt_done_q;
    assign accel_rsp.rd_valid = rd_valid_q;
    assign accel_rsp.rd_data  = rd_line;

endmodule

//--- cpu_boot_top.sv
// top level: boot loader, block address generator and data memory
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_boot_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ready,      // host level, starts the fill
    input  host_pkg::host_rsp_t host_rsp,
    output host_pkg::host_req_t host_req,
    input  mem_pkg::accel_req_t accel_req,
    output mem_pkg::accel_rsp_t accel_rsp,
    output logic                booted
);

    logic [`CPU_ADDR_W-1:0] block_addr;
    logic [`CPU_ADDR_W-1:0] word_addr;
    logic                   last_block;
    logic                   set;
    logic                   inc;
    logic                   next_block;
    mem_pkg::dm_wr_t        dm_wr;      // loader -> memory

    //////////////////////////////////////////////////
    // boot path
    //////////////////////////////////////////////////
    boot_loader i_loader (
        .clk        (clk),
        .rst_n      (rst_n),
        .ready      (ready),
        .host_rsp   (host_rsp),
        .host_req   (host_req),
        .block_addr (block_addr),
        .word_addr  (word_addr),
        .last_block (last_block),
        .set        (set),
        .inc        (inc),
        .next_block (next_block),
        .dm_wr      (dm_wr),
        .booted     (booted)
    );

    boot_addr_gen i_addr_gen (
        .clk        (clk),
        .rst_n      (rst_n),
        .set        (set),
        .inc        (inc),
        .next_block (next_block),
        .block_addr (block_addr),
        .word_addr  (word_addr),
        .last_block (last_block)
    );

    // memory, also serves the accelerator once booted
    data_mem i_data_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .dm_wr      (dm_wr),
        .booted     (booted),
        .accel_req  (accel_req),
        .accel_rsp  (accel_rsp)
    );

endmodule

//--- tb_clk_gen.sv
// testbench clock and power-on reset generator
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int period_ns  = 40,
    parameter int rst_cycles = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    // reset held low for a fixed number of rising edges
    initial begin
        rst_n = 1'b0;
        repeat (rst_cycles) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- tb_cpu_boot.sv
// boot path testbench: host model, data memory shadow, directed accelerator tests
`timescale 1ns/1ps
`include "cpu_macros.svh"

module tb_cpu_boot;

    localparam int req_timeout  = 40;   // cycles for the loader to ask for a block
    localparam int boot_timeout = 20;

    logic                   clk;
    logic                   rst_n;
    logic                   ready;
    logic                   booted;
    host_pkg::host_rsp_t    host_rsp;
    host_pkg::host_req_t    host_req;
    mem_pkg::accel_req_t    accel_req;
    mem_pkg::accel_rsp_t    accel_rsp;

    logic [`CPU_DATA_W-1:0] shadow [0:`CPU_DM_WORDS-1];   // expected memory contents
    integer                 seed;
    int                     pass_cnt;
    int                     fail_cnt;
    bit                     boot_ok;
    int                     req_seen;     // new host read requests seen so far
    host_pkg::host_op_t     prev_op;
    logic [`CPU_ADDR_W-1:0] prev_addr;

    tb_clk_gen i_clk_gen (.clk(clk), .rst_n(rst_n));

    cpu_boot_top i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .ready     (ready),
        .host_rsp  (host_rsp),
        .host_req  (host_req),
        .accel_req (accel_req),
        .accel_rsp (accel_rsp),
        .booted    (booted)
    );

    // a request is new when op turns to read or the address moves
    always @(negedge clk) begin
        if (host_req.op == host_pkg::host_read &&
            (prev_op != host_pkg::host_read || host_req.addr != prev_addr)) begin
            req_seen++;
        end
        prev_op   = host_req.op;
        prev_addr = host_req.addr;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    function automatic logic [`CPU_ADDR_W-1:0] expected_base(input int k);
        int base;
        if (k == `CPU_DM_BLOCKS - 1) begin
            base = 'h0100;
        end else begin
            base = 'h1000 * (1 + k / 4) + 'h100 * ((k / 2) % 2) + 'h40 * (k % 2);
        end
        return base[`CPU_ADDR_W-1:0];
    endfunction

    function automatic logic [`CPU_LINE_W-1:0] shadow_line(input logic [`CPU_ADDR_W-1:0] addr);
        logic [`CPU_LINE_W-1:0] line;
        for (int i = 0; i < `CPU_LINE_WORDS; i++) begin
            line[i*`CPU_DATA_W +: `CPU_DATA_W] = shadow[{addr[15:6], 4'(i)}];
        end
        return line;
    endfunction

    // some word inside one of the loaded blocks
    function automatic logic [`CPU_ADDR_W-1:0] random_loaded_addr();
        int k;
        int w;
        k = $unsigned($random(seed)) % `CPU_DM_BLOCKS;
        w = $unsigned($random(seed)) % `CPU_LINE_WORDS;
        return expected_base(k) + 16'(w * 4);
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) begin
            pass_cnt++;
        end else begin
            $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
            fail_cnt++;
        end
    endtask

    task automatic expect_event(input bit ok, input string what);
        assert (ok) begin
            pass_cnt++;
        end else begin
            $display("%s", what);
            fail_cnt++;
        end
    endtask

    task automatic compare_line(input logic [`CPU_ADDR_W-1:0] addr,
                                input logic [`CPU_LINE_W-1:0] got,
                                input logic [`CPU_LINE_W-1:0] exp);
        for (int i = 0; i < `CPU_LINE_WORDS; i++) begin
            check_value($sformatf("accel_rsp.rd_data word %0d of line 0x%04h", i,
                                  addr & 16'hffc0),
                        got[i*`CPU_DATA_W +: `CPU_DATA_W], exp[i*`CPU_DATA_W +: `CPU_DATA_W]);
        end
    endtask

    task automatic drive_accel(input logic wrt_en, input logic rd_en,
                               input logic [`CPU_ADDR_W-1:0] addr,
                               input logic [`CPU_DATA_W-1:0] data);
        accel_req.wrt_en   <= wrt_en;
        accel_req.rd_en    <= rd_en;
        accel_req.addr     <= addr;
        accel_req.wrt_data <= data;
    endtask

    // one line read with its response due one cycle after the request edge
    task automatic read_and_check(input logic [`CPU_ADDR_W-1:0] addr);
        logic [`CPU_LINE_W-1:0] exp;
        exp = shadow_line(addr);
        @(posedge clk);
        drive_accel(1'b0, 1'b1, addr, '0);
        @(posedge clk);
        drive_accel(1'b0, 1'b0, '0, '0);
        @(negedge clk);
        check_value("accel_rsp.rd_valid", 32'(accel_rsp.rd_valid), 32'h1);
        compare_line(addr, accel_rsp.rd_data, exp);
    endtask

    task automatic report_test(input string name, input int fails_before);
        $display("test %s finished with %0d errors", name, fail_cnt - fails_before);
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////
    task automatic test_reset_wait();
        int fails_before;
        int cnt;
        int r;
        fails_before = fail_cnt;
        cnt = 0;
        while (rst_n !== 1'b1 && cnt < 20) begin
            @(posedge clk);
            cnt++;
        end
        expect_event(rst_n === 1'b1, "timeout: reset was never released");
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            r = $random(seed);
            if (i < 9) begin
                drive_accel(r[0], r[1] | ~r[0], {r[15:2], 2'b00}, r);  // ignored before boot
            end else begin
                drive_accel(1'b0, 1'b0, '0, '0);
            end
            @(negedge clk);
            check_value("host_req.op", 32'(host_req.op), 32'(host_pkg::host_idle));
            check_value("booted", 32'(booted), 32'h0);
            check_value("accel_rsp.wrt_done", 32'(accel_rsp.wrt_done), 32'h0);
            check_value("accel_rsp.rd_valid", 32'(accel_rsp.rd_valid), 32'h0);
        end
        report_test("reset_wait", fails_before);
    endtask

    task automatic test_boot_sequence();
        int                     fails_before;
        int                     cnt;
        int                     gap;
        logic [`CPU_ADDR_W-1:0] base;
        logic [`CPU_DATA_W-1:0] word;
        fails_before = fail_cnt;
        @(posedge clk);
        ready <= 1'b1;
        for (int k = 0; k < `CPU_DM_BLOCKS; k++) begin
            cnt = 0;
            @(negedge clk);
            while (host_req.op != host_pkg::host_read && cnt < req_timeout) begin
                @(negedge clk);
                cnt++;
            end
            if (host_req.op != host_pkg::host_read) begin
                expect_event(1'b0, $sformatf("timeout: no host read request for block %0d", k));
                report_test("boot_sequence", fails_before);
                return;
            end
            base = expected_base(k);
            check_value("host_req.addr", 32'(host_req.addr), 32'(base));
            check_value("booted", 32'(booted), 32'h0);
            gap = $unsigned($random(seed)) % 6;     // host think time
            repeat (gap) @(posedge clk);
            for (int i = 0; i < `CPU_LINE_WORDS; i++) begin
                word = $random(seed);
                @(posedge clk);
                host_rsp.rd_valid <= (i == 0);
                host_rsp.tx_done  <= (i == `CPU_LINE_WORDS - 1);
                host_rsp.data     <= word;
                shadow[base[15:2] + 14'(i)] = word;
            end
            @(posedge clk);
            host_rsp <= '0;
        end
        cnt = 0;
        @(negedge clk);
        while (booted !== 1'b1 && cnt < boot_timeout) begin
            @(negedge clk);
            cnt++;
        end
        expect_event(booted === 1'b1, "timeout: booted never rose after the last block");
        boot_ok = (booted === 1'b1);
        // link must stay quiet once booted
        for (int i = 0; i < 4; i++) begin
            check_value("host_req.op", 32'(host_req.op), 32'(host_pkg::host_idle));
            @(negedge clk);
        end
        @(posedge clk);
        check_value("host read request count", 32'(req_seen), 32'(`CPU_DM_BLOCKS));
        report_test("boot_sequence", fails_before);
    endtask

    task automatic test_loaded_contents();
        int fails_before;
        int off;
        fails_before = fail_cnt;
        for (int k = 0; k < `CPU_DM_BLOCKS; k++) begin
            off = $unsigned($random(seed)) % `CPU_LINE_WORDS;
            read_and_check(expected_base(k) + 16'(off * 4));
        end
        report_test("loaded_contents", fails_before);
    endtask

    task automatic test_word_write();
        int                     fails_before;
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] data;
        logic [`CPU_ADDR_W-1:0] wr_addr [0:7];
        fails_before = fail_cnt;
        for (int j = 0; j < 8; j++) begin
            addr = random_loaded_addr();
            data = $random(seed);
            wr_addr[j] = addr;
            @(posedge clk);
            drive_accel(1'b1, 1'b0, addr, data);
            shadow[addr[15:2]] = data;
            @(posedge clk);
            drive_accel(1'b0, 1'b0, '0, '0);
            @(negedge clk);
            check_value("accel_rsp.wrt_done", 32'(accel_rsp.wrt_done), 32'h1);
        end
        for (int j = 0; j < 8; j++) begin
            read_and_check(wr_addr[j]);
        end
        report_test("word_write", fails_before);
    endtask

    task automatic test_back_to_back();
        int                     fails_before;
        logic [`CPU_ADDR_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] data;
        logic [`CPU_ADDR_W-1:0] req_addr [0:7];
        logic                   req_wr [0:7];
        logic [`CPU_LINE_W-1:0] exp_line [0:7];
        fails_before = fail_cnt;
        for (int i = 0; i <= 8; i++) begin
            @(posedge clk);
            if (i < 8) begin
                // even slots read and write together, odd slots reread that line
                if (i % 2 == 0) begin
                    addr = random_loaded_addr();
                end else begin
                    addr = req_addr[i-1];
                end
                data = $random(seed);
                req_addr[i] = addr;
                req_wr[i]   = (i % 2 == 0);
                exp_line[i] = shadow_line(addr);     // old contents for a combined request
                if (req_wr[i]) shadow[addr[15:2]] = data;
                drive_accel(req_wr[i], 1'b1, addr, data);
            end else begin
                drive_accel(1'b0, 1'b0, '0, '0);
            end
            @(negedge clk);
            if (i > 0) begin
                check_value("accel_rsp.rd_valid", 32'(accel_rsp.rd_valid), 32'h1);
                check_value("accel_rsp.wrt_done", 32'(accel_rsp.wrt_done), 32'(req_wr[i-1]));
                compare_line(req_addr[i-1], accel_rsp.rd_data, exp_line[i-1]);
            end
        end
        report_test("back_to_back", fails_before);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial begin
        seed      = 32'h93f84d7d;
        pass_cnt  = 0;
        fail_cnt  = 0;
        boot_ok   = 1'b0;
        req_seen  = 0;
        prev_op   = host_pkg::host_idle;
        prev_addr = '0;
        ready     = 1'b0;
        host_rsp  = '0;
        accel_req = '0;
        test_reset_wait();
        test_boot_sequence();
        if (boot_ok) begin      // memory tests need a finished boot
            test_loaded_contents();
            test_word_write();
            test_back_to_back();
        end
        $display("pass count %0d, fail count %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
host_pkg.sv
mem_pkg.sv
boot_addr_gen.sv
boot_loader.sv
data_mem.sv
cpu_boot_top.sv
tb_clk_gen.sv
tb_cpu_boot.sv

//--- run_sim.sh
#!/bin/sh
# build and run the boot path testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --top-module tb_cpu_boot -f verilog.f -o sim_tb > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
grep -q "ALL CHECKS PASSED" sim.log && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
